// ==== include/u2_params.svh ====
// Radio core constants: settings map, bus widths, FIFO depth and version number
`ifndef U2_PARAMS_SVH
`define U2_PARAMS_SVH

//////////////////////////////
// Settings base addresses
`define U2_SR_MISC       0
`define U2_SR_TIME64     10
`define U2_SR_RX_CTRL    32

// Misc register offsets
`define U2_MISC_CLK      0
`define U2_MISC_ADC      2
`define U2_MISC_LED_SW   3
`define U2_MISC_PHY      4
`define U2_MISC_LED_SRC  6

// Time register offsets
`define U2_TIME_HI       0
`define U2_TIME_LO       1
`define U2_TIME_CTRL     2

// Receive control offsets
`define U2_RX_NSAMPS     0
`define U2_RX_CMD        1

//////////////////////////////
// Widths and sizes
`define U2_SET_AW        8
`define U2_SET_DW        32
`define U2_LINE_W        36
`define U2_FIFO_DEPTH    16

`define U2_LED_SRC_RESET 8'h1E
// Major in the upper half, minor in the lower
`define U2_COMPAT_NUM    {16'd7, 16'd0}

`endif

// ==== design/u2_pkg.sv ====
// Shared types of the radio core: settings bus, stream line, control lines, framer states
`default_nettype none

`include "u2_params.svh"

package u2_pkg;

   // One settings write, valid where stb is high
   typedef struct packed {
      logic                   stb;
      logic [`U2_SET_AW-1:0]  addr;
      logic [`U2_SET_DW-1:0]  data;
   } set_bus_t;

   // Stream line, flags above the payload
   typedef struct packed {
      logic        eof;
      logic        sof;
      logic [1:0]  spare;
      logic [31:0] payload;
   } stream_line_t;

   // Clock generator, ADC and PHY control lines
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset;
   } ctrl_out_t;

   //////////////////////////////
   // Receive framer states
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      HDR_HI  = 3'd1,
      HDR_LO  = 3'd2,
      SAMPLES = 3'd3,
      HALT    = 3'd4
   } framer_state_t;

endpackage

`default_nettype wire

// ==== design/u2_setting_regs.sv ====
// Misc control registers for clock, ADC, PHY and LEDs, with the LED source mux
`timescale 1ns/1ps
`default_nettype none

`include "u2_params.svh"

module u2_setting_regs (
   input  wire                 dsp_clk,
   input  wire                 reset_i,
   input  u2_pkg::set_bus_t    set_i,
   input  wire                 run_rx_i,
   input  wire                 clk_status_i,
   output u2_pkg::ctrl_out_t   ctrl_o,
   output logic [7:0]          leds_o
);

   localparam logic [7:0] ADDR_CLK     = 8'(`U2_SR_MISC + `U2_MISC_CLK);
   localparam logic [7:0] ADDR_ADC     = 8'(`U2_SR_MISC + `U2_MISC_ADC);
   localparam logic [7:0] ADDR_LED_SW  = 8'(`U2_SR_MISC + `U2_MISC_LED_SW);
   localparam logic [7:0] ADDR_PHY     = 8'(`U2_SR_MISC + `U2_MISC_PHY);
   localparam logic [7:0] ADDR_LED_SRC = 8'(`U2_SR_MISC + `U2_MISC_LED_SRC);

   logic [4:0] clk_reg;
   logic [3:0] adc_reg;
   logic       phy_reg;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   //////////////////////////////
   // Register bank
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         clk_reg <= '0;
         adc_reg <= '0;
         phy_reg <= 1'b0;
         led_sw  <= '0;
         led_src <= `U2_LED_SRC_RESET;
      end else if (set_i.stb) begin
         case (set_i.addr)
            ADDR_CLK:     clk_reg <= set_i.data[4:0];
            ADDR_ADC:     adc_reg <= set_i.data[3:0];
            ADDR_LED_SW:  led_sw  <= set_i.data[7:0];
            ADDR_PHY:     phy_reg <= set_i.data[0];
            ADDR_LED_SRC: led_src <= set_i.data[7:0];
            default: ;
         endcase
      end
   end

   // Clock word is {ready, en[1:0], sel[1:0]}
   assign ctrl_o.clock_ready = clk_reg[4];
   assign ctrl_o.clk_en      = clk_reg[3:2];
   assign ctrl_o.clk_sel     = clk_reg[1:0];
   assign ctrl_o.adc_oe_a    = adc_reg[3];
   assign ctrl_o.adc_on_a    = adc_reg[2];
   assign ctrl_o.adc_oe_b    = adc_reg[1];
   assign ctrl_o.adc_on_b    = adc_reg[0];
   assign ctrl_o.phy_reset   = phy_reg;

   //////////////////////////////
   // LED mux, source bit 1 selects hardware
   assign led_hw = {5'b0, clk_status_i, run_rx_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

// ==== design/u2_vita_time.sv ====
// VITA 64-bit time counter with staged load, PPS synchronizer and PPS capture
`timescale 1ns/1ps
`default_nettype none

`include "u2_params.svh"

module u2_vita_time (
   input  wire               dsp_clk,
   input  wire               reset_i,
   input  u2_pkg::set_bus_t  set_i,
   input  wire               pps_i,
   output logic [63:0]       vita_time_o,
   output logic [63:0]       vita_time_pps_o,
   output logic              pps_int_o
);

   localparam logic [7:0] ADDR_HI   = 8'(`U2_SR_TIME64 + `U2_TIME_HI);
   localparam logic [7:0] ADDR_LO   = 8'(`U2_SR_TIME64 + `U2_TIME_LO);
   localparam logic [7:0] ADDR_CTRL = 8'(`U2_SR_TIME64 + `U2_TIME_CTRL);

   logic [31:0] staged_hi;
   logic [31:0] staged_lo;
   logic        armed;
   logic        pps_s1;
   logic        pps_s2;
   logic        pps_d3;
   logic        pps_edge;
   logic        ctrl_wr;

   // Staged words, written ahead of a load
   always_ff @(posedge dsp_clk) begin
      if (set_i.stb && set_i.addr == ADDR_HI)
         staged_hi <= set_i.data;
      if (set_i.stb && set_i.addr == ADDR_LO)
         staged_lo <= set_i.data;
   end

   //////////////////////////////
   // PPS sync and edge detect
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_d3 <= 1'b0;
      end else begin
         pps_s1 <= pps_i;
         pps_s2 <= pps_s1;
         pps_d3 <= pps_s2;
      end
   end

   assign pps_edge = pps_s2 & ~pps_d3;
   assign ctrl_wr  = set_i.stb && set_i.addr == ADDR_CTRL;

   //////////////////////////////
   // Counter, immediate or PPS-timed load
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         armed           <= 1'b0;
         pps_int_o       <= 1'b0;
      end else begin
         pps_int_o <= pps_edge;
         if (pps_edge)
            vita_time_pps_o <= vita_time_o;

         if (ctrl_wr && set_i.data[0]) begin
            vita_time_o <= {staged_hi, staged_lo};
            armed       <= 1'b0;
         end else if (pps_edge && armed) begin
            vita_time_o <= {staged_hi, staged_lo};
            armed       <= 1'b0;
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
            // Bit 0 low waits for the next PPS
            if (ctrl_wr)
               armed <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/u2_rx_framer.sv ====
// Receive framer: builds timestamped sample packets into a line FIFO, flags overrun
`timescale 1ns/1ps
`default_nettype none

`include "u2_params.svh"

module u2_rx_framer (
   input  wire                    dsp_clk,
   input  wire                    reset_i,
   input  u2_pkg::set_bus_t       set_i,
   input  wire [63:0]             vita_time_i,
   input  wire [31:0]             sample_i,
   input  wire                    sample_stb_i,
   output u2_pkg::stream_line_t   rx_line_o,
   output logic                   rx_src_rdy_o,
   input  wire                    rx_dst_rdy_i,
   output logic                   run_rx_o,
   output logic                   overrun_o
);

   localparam logic [7:0] ADDR_NSAMPS = 8'(`U2_SR_RX_CTRL + `U2_RX_NSAMPS);
   localparam logic [7:0] ADDR_CMD    = 8'(`U2_SR_RX_CTRL + `U2_RX_CMD);
   localparam int         PW          = $clog2(`U2_FIFO_DEPTH);

   u2_pkg::framer_state_t state;
   u2_pkg::stream_line_t  mem [`U2_FIFO_DEPTH];
   u2_pkg::stream_line_t  line_a;
   u2_pkg::stream_line_t  line_b;

   logic [15:0] nsamps;
   logic [15:0] n_eff;
   logic [15:0] pkts_left;
   logic [15:0] cnt;
   logic [31:0] hold_sample;
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;
   logic [PW:0]   free;
   logic [1:0]    wr_n;
   logic          rd;
   logic          room;
   logic          last;
   logic          cmd_start;

   // Packets carry at least two samples
   assign n_eff     = (nsamps < 16'd2) ? 16'd2 : nsamps;
   assign free      = (PW+1)'(`U2_FIFO_DEPTH) - count;
   assign room      = free >= (PW+1)'(3);
   assign last      = (cnt + 16'd1) == n_eff;
   assign cmd_start = set_i.stb && set_i.addr == ADDR_CMD && set_i.data[15:0] != 16'd0;
   assign run_rx_o  = (state != u2_pkg::IDLE) && (state != u2_pkg::HALT);

   always_ff @(posedge dsp_clk) begin
      if (reset_i)
         nsamps <= '0;
      else if (set_i.stb && set_i.addr == ADDR_NSAMPS)
         nsamps <= set_i.data[15:0];
   end

   //////////////////////////////
   // Lines written this cycle
   always_comb begin
      wr_n   = 2'd0;
      line_a = '0;
      line_b = '0;
      case (state)
         u2_pkg::HDR_HI: begin
            if (sample_stb_i && room) begin
               line_a.sof     = 1'b1;
               line_a.payload = vita_time_i[63:32];
               line_b.payload = vita_time_i[31:0];
               wr_n           = 2'd2;
            end
         end
         u2_pkg::HDR_LO: begin
            // First sample always has its slot reserved
            line_a.payload = hold_sample;
            line_a.eof     = sample_stb_i && !room;
            wr_n           = 2'd1;
            if (sample_stb_i && room) begin
               line_b.payload = sample_i;
               line_b.eof     = last;
               wr_n           = 2'd2;
            end
         end
         u2_pkg::SAMPLES: begin
            if (sample_stb_i) begin
               // On overrun an empty eof line closes the packet
               line_a.payload = room ? sample_i : 32'd0;
               line_a.eof     = room ? last : 1'b1;
               wr_n           = 2'd1;
            end
         end
         default: ;
      endcase
   end

   //////////////////////////////
   // Framer FSM
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         state     <= u2_pkg::IDLE;
         pkts_left <= '0;
         cnt       <= '0;
         overrun_o <= 1'b0;
      end else begin
         overrun_o <= 1'b0;
         case (state)
            u2_pkg::IDLE, u2_pkg::HALT: begin
               if (cmd_start) begin
                  pkts_left <= set_i.data[15:0];
                  cnt       <= '0;
                  state     <= u2_pkg::HDR_HI;
               end
            end
            u2_pkg::HDR_HI: begin
               if (sample_stb_i && room) begin
                  cnt   <= 16'd1;
                  state <= u2_pkg::HDR_LO;
               end else if (sample_stb_i) begin
                  overrun_o <= 1'b1;
                  state     <= u2_pkg::HALT;
               end
            end
            default: begin
               // HDR_LO and SAMPLES share the sample handling
               if (sample_stb_i && !room) begin
                  overrun_o <= 1'b1;
                  state     <= u2_pkg::HALT;
               end else if (sample_stb_i && last) begin
                  cnt       <= '0;
                  pkts_left <= pkts_left - 16'd1;
                  state     <= (pkts_left == 16'd1) ? u2_pkg::IDLE : u2_pkg::HDR_HI;
               end else begin
                  if (sample_stb_i)
                     cnt <= cnt + 16'd1;
                  state <= u2_pkg::SAMPLES;
               end
            end
         endcase
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (state == u2_pkg::HDR_HI && sample_stb_i)
         hold_sample <= sample_i;
   end

   //////////////////////////////
   // Line FIFO
   assign rx_src_rdy_o = count != '0;
   assign rx_line_o    = mem[rd_ptr];
   assign rd           = rx_src_rdy_o && rx_dst_rdy_i;

   always_ff @(posedge dsp_clk) begin
      if (wr_n != 2'd0)
         mem[wr_ptr] <= line_a;
      if (wr_n == 2'd2)
         mem[wr_ptr + PW'(1)] <= line_b;
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         wr_ptr <= wr_ptr + PW'(wr_n);
         if (rd)
            rd_ptr <= rd_ptr + PW'(1);
         count <= count + (PW+1)'(wr_n) - (PW+1)'(rd);
      end
   end

endmodule

`default_nettype wire

// ==== design/u2_readback_mux.sv ====
// Registered readback of version number, VITA time and PPS capture
`timescale 1ns/1ps
`default_nettype none

`include "u2_params.svh"

module u2_readback_mux (
   input  wire          dsp_clk,
   input  wire          reset_i,
   input  wire [3:0]    rb_addr_i,
   input  wire [63:0]   vita_time_i,
   input  wire [63:0]   vita_time_pps_i,
   output logic [31:0]  rb_data_o
);

   logic [31:0] rb_word;

   //////////////////////////////
   // Word select
   always_comb begin
      case (rb_addr_i)
         4'd0:    rb_word = `U2_COMPAT_NUM;
         4'd1:    rb_word = vita_time_i[63:32];
         4'd2:    rb_word = vita_time_i[31:0];
         4'd3:    rb_word = vita_time_pps_i[63:32];
         4'd4:    rb_word = vita_time_pps_i[31:0];
         default: rb_word = 32'd0;
      endcase
   end

   // One cycle behind the address
   always_ff @(posedge dsp_clk) begin
      if (reset_i)
         rb_data_o <= '0;
      else
         rb_data_o <= rb_word;
   end

endmodule

`default_nettype wire

// ==== design/u2_core.sv ====
// Radio core top on dsp_clk: control registers, VITA time, receive framer, readback
`timescale 1ns/1ps
`default_nettype none

module u2_core (
   input  wire                    dsp_clk,
   input  wire                    reset_i,
   input  u2_pkg::set_bus_t       set_i,
   input  wire                    pps_i,
   input  wire                    clk_status_i,
   input  wire [31:0]             sample_i,
   input  wire                    sample_stb_i,
   output u2_pkg::stream_line_t   rx_line_o,
   output logic                   rx_src_rdy_o,
   input  wire                    rx_dst_rdy_i,
   input  wire [3:0]              rb_addr_i,
   output logic [31:0]            rb_data_o,
   output u2_pkg::ctrl_out_t      ctrl_o,
   output logic                   phy_resetn_o,
   output logic [7:0]             leds_o,
   output logic                   pps_int_o,
   output logic                   overrun_o
);

   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;
   logic        run_rx;

   //////////////////////////////
   // Control registers and LEDs
   u2_setting_regs setting_regs (
      .dsp_clk      (dsp_clk),
      .reset_i      (reset_i),
      .set_i        (set_i),
      .run_rx_i     (run_rx),
      .clk_status_i (clk_status_i),
      .ctrl_o       (ctrl_o),
      .leds_o       (leds_o)
   );

   // PHY reset pin is active low
   assign phy_resetn_o = ~ctrl_o.phy_reset;

   //////////////////////////////
   // VITA timing
   u2_vita_time vita_time_gen (
      .dsp_clk         (dsp_clk),
      .reset_i         (reset_i),
      .set_i           (set_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int_o)
   );

   //////////////////////////////
   // Receive framing
   u2_rx_framer rx_framer (
      .dsp_clk      (dsp_clk),
      .reset_i      (reset_i),
      .set_i        (set_i),
      .vita_time_i  (vita_time),
      .sample_i     (sample_i),
      .sample_stb_i (sample_stb_i),
      .rx_line_o    (rx_line_o),
      .rx_src_rdy_o (rx_src_rdy_o),
      .rx_dst_rdy_i (rx_dst_rdy_i),
      .run_rx_o     (run_rx),
      .overrun_o    (overrun_o)
   );

   //////////////////////////////
   // Readback
   u2_readback_mux readback_mux (
      .dsp_clk         (dsp_clk),
      .reset_i         (reset_i),
      .rb_addr_i       (rb_addr_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .rb_data_o       (rb_data_o)
   );

endmodule

`default_nettype wire

// ==== verif/u2_core_checker.sv ====
// Stream protocol assertions for the receive framer, attached by bind
`timescale 1ns/1ps
`default_nettype none

module u2_core_checker (
   input  wire                    dsp_clk,
   input  wire                    reset_i,
   input  u2_pkg::stream_line_t   line_i,
   input  wire                    src_rdy_i,
   input  wire                    dst_rdy_i,
   input  wire                    run_rx_i,
   input  wire                    overrun_i
);

   int   fail_count = 0;
   logic in_pkt;
   logic xfer;

   assign xfer = src_rdy_i && dst_rdy_i;

   // Tracks whether a packet has started but not yet ended
   always_ff @(posedge dsp_clk) begin
      if (reset_i)
         in_pkt <= 1'b0;
      else if (xfer && line_i.eof)
         in_pkt <= 1'b0;
      else if (xfer && line_i.sof)
         in_pkt <= 1'b1;
   end

   //////////////////////////////
   // Stalled line holds still
   held_line: assert property (@(posedge dsp_clk) disable iff (reset_i)
      src_rdy_i && !dst_rdy_i |=> src_rdy_i && $stable(line_i))
      else begin
         fail_count++;
         $error("stream line changed while the sink was stalled");
      end

   // A new packet only after the previous eof
   sof_after_eof: assert property (@(posedge dsp_clk) disable iff (reset_i)
      xfer && line_i.sof |-> !in_pkt)
      else begin
         fail_count++;
         $error("sof transferred inside an open packet");
      end

   // Overrun pulse arrives with the FSM already halted
   halt_on_overrun: assert property (@(posedge dsp_clk) disable iff (reset_i)
      overrun_i |-> !run_rx_i)
      else begin
         fail_count++;
         $error("run_rx still high during overrun");
      end

endmodule

bind u2_rx_framer u2_core_checker framer_checker (
   .dsp_clk   (dsp_clk),
   .reset_i   (reset_i),
   .line_i    (rx_line_o),
   .src_rdy_i (rx_src_rdy_o),
   .dst_rdy_i (rx_dst_rdy_i),
   .run_rx_i  (run_rx_o),
   .overrun_i (overrun_o)
);

`default_nettype wire

// ==== verif/u2_core_tb.sv ====
// Directed testbench for the radio core: registers, VITA time, framing and overrun
`timescale 1ns/1ps
`default_nettype none

`include "u2_params.svh"

module u2_core_tb;

   localparam int CLK_PERIOD = 20;
   localparam int N_SAMPS    = 4;
   localparam int N_PKTS     = 3;
   localparam int STB_GAP    = 3;

   // Cycle budgets per test, summed for the watchdog
   localparam int WATCHDOG_CYCLES = 10 + 40 + 60 + 300 + 500 + 200 + 200;

   logic                 dsp_clk;
   logic                 reset;
   u2_pkg::set_bus_t     set_bus;
   logic                 pps;
   logic                 clk_status;
   logic [31:0]          sample;
   logic                 sample_stb;
   u2_pkg::stream_line_t rx_line;
   logic                 rx_src_rdy;
   logic                 rx_dst_rdy;
   logic [3:0]           rb_addr;
   logic [31:0]          rb_data;
   u2_pkg::ctrl_out_t    ctrl;
   logic                 phy_resetn;
   logic [7:0]           leds;
   logic                 pps_int;
   logic                 overrun;

   logic [31:0]          sent_q[$];
   u2_pkg::stream_line_t got_q[$];

   u2_core UUT (
      .dsp_clk      (dsp_clk),
      .reset_i      (reset),
      .set_i        (set_bus),
      .pps_i        (pps),
      .clk_status_i (clk_status),
      .sample_i     (sample),
      .sample_stb_i (sample_stb),
      .rx_line_o    (rx_line),
      .rx_src_rdy_o (rx_src_rdy),
      .rx_dst_rdy_i (rx_dst_rdy),
      .rb_addr_i    (rb_addr),
      .rb_data_o    (rb_data),
      .ctrl_o       (ctrl),
      .phy_resetn_o (phy_resetn),
      .leds_o       (leds),
      .pps_int_o    (pps_int),
      .overrun_o    (overrun)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      abort_run("watchdog expired before the tests finished");
   end

   initial begin
      wait (UUT.rx_framer.framer_checker.fail_count != 0);
      abort_run("stream assertion reported an error");
   end

   //////////////////////////////
   // Helpers
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s = 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         $display("Test failed");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic write_setting(input int addr, input logic [31:0] data);
      @(negedge dsp_clk);
      set_bus.stb  = 1'b1;
      set_bus.addr = 8'(addr);
      set_bus.data = data;
      @(negedge dsp_clk);
      set_bus.stb = 1'b0;
   endtask

   task automatic read_word(input logic [3:0] addr, output logic [31:0] data);
      @(negedge dsp_clk);
      rb_addr = addr;
      @(negedge dsp_clk);
      data = rb_data;
   endtask

   // Source bit high picks the hardware bit, run_rx in 1 and clk_status in 2
   function automatic logic [7:0] expected_leds(input logic [7:0] src, input logic [7:0] sw,
                                                input logic run, input logic status);
      logic [7:0] hw;
      logic [7:0] leds_exp;
      hw    = 8'h00;
      hw[1] = run;
      hw[2] = status;
      for (int i = 0; i < 8; i++)
         leds_exp[i] = src[i] ? hw[i] : sw[i];
      return leds_exp;
   endfunction

   // Two PPS rises spacing cycles apart, low PPS capture read after each
   task automatic pps_captures(input int spacing, output logic [31:0] first,
                               output logic [31:0] second);
      @(negedge dsp_clk);
      rb_addr = 4'd4;
      pps     = 1'b1;
      repeat (3) @(negedge dsp_clk);
      // Interrupt pulse lines up with the capture edge
      check_value("pps_int_o at capture", pps_int, 1'b1);
      @(negedge dsp_clk);
      check_value("pps_int_o after capture", pps_int, 1'b0);
      pps = 1'b0;
      repeat (4) @(negedge dsp_clk);
      first = rb_data;
      repeat (spacing - 8) @(negedge dsp_clk);
      pps = 1'b1;
      repeat (4) @(negedge dsp_clk);
      pps = 1'b0;
      repeat (4) @(negedge dsp_clk);
      second = rb_data;
   endtask

   task automatic drive_samples(input int count, input int gap);
      for (int i = 0; i < count; i++) begin
         @(negedge dsp_clk);
         sample     = $urandom;
         sample_stb = 1'b1;
         sent_q.push_back(sample);
         @(negedge dsp_clk);
         sample_stb = 1'b0;
         repeat (gap - 2) @(negedge dsp_clk);
      end
   endtask

   // Random back-pressure, one line per transfer
   task automatic collect_lines(input int count, input int limit);
      int waited;
      waited = 0;
      while (got_q.size() < count) begin
         @(negedge dsp_clk);
         rx_dst_rdy = ($urandom % 4) != 0;
         if (rx_dst_rdy && rx_src_rdy)
            got_q.push_back(rx_line);
         waited++;
         if (waited > limit)
            abort_run("receive stream stalled before all lines arrived");
      end
   endtask

   //////////////////////////////
   // Tests
   task automatic test_reset_state();
      logic [31:0] word;
      check_value("ctrl_o", ctrl, '0);
      check_value("phy_resetn_o", phy_resetn, 1'b1);
      check_value("leds_o", leds, expected_leds(`U2_LED_SRC_RESET, 8'h00, 1'b0, clk_status));
      check_value("rx_src_rdy_o", rx_src_rdy, 1'b0);
      check_value("overrun_o", overrun, 1'b0);
      check_value("pps_int_o", pps_int, 1'b0);
      read_word(4'd0, word);
      check_value("rb_data_o word 0", word, `U2_COMPAT_NUM);
      for (int a = 5; a < 16; a++) begin
         read_word(4'(a), word);
         check_value("rb_data_o unused word", word, 32'd0);
      end
   endtask

   task automatic test_control_regs();
      logic [4:0]        clk_val;
      logic [3:0]        adc_val;
      logic [7:0]        sw_val;
      logic [7:0]        src_val;
      u2_pkg::ctrl_out_t exp;
      clk_val = 5'($urandom);
      adc_val = 4'($urandom);
      write_setting(`U2_SR_MISC + `U2_MISC_CLK, 32'(clk_val));
      write_setting(`U2_SR_MISC + `U2_MISC_ADC, 32'(adc_val));
      write_setting(`U2_SR_MISC + `U2_MISC_PHY, 32'd1);
      exp             = '0;
      exp.clock_ready = clk_val[4];
      exp.clk_en      = clk_val[3:2];
      exp.clk_sel     = clk_val[1:0];
      exp.adc_oe_a    = adc_val[3];
      exp.adc_on_a    = adc_val[2];
      exp.adc_oe_b    = adc_val[1];
      exp.adc_on_b    = adc_val[0];
      exp.phy_reset   = 1'b1;
      check_value("ctrl_o", ctrl, exp);
      check_value("phy_resetn_o", phy_resetn, 1'b0);
      write_setting(`U2_SR_MISC + `U2_MISC_PHY, 32'd0);
      check_value("phy_resetn_o", phy_resetn, 1'b1);
      repeat (4) begin
         sw_val     = 8'($urandom);
         src_val    = 8'($urandom);
         clk_status = 1'($urandom);
         write_setting(`U2_SR_MISC + `U2_MISC_LED_SW, 32'(sw_val));
         write_setting(`U2_SR_MISC + `U2_MISC_LED_SRC, 32'(src_val));
         check_value("leds_o", leds, expected_leds(src_val, sw_val, 1'b0, clk_status));
      end
      write_setting(`U2_SR_MISC + `U2_MISC_LED_SRC, 32'(`U2_LED_SRC_RESET));
      write_setting(`U2_SR_MISC + `U2_MISC_LED_SW, 32'd0);
   endtask

   task automatic test_vita_time();
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] t0;
      logic [31:0] t1;
      int          k;
      int          m;
      // Small low words keep the high word free of carries
      hi = $urandom;
      lo = $urandom & 32'h0FFF_FFFF;
      write_setting(`U2_SR_TIME64 + `U2_TIME_HI, hi);
      write_setting(`U2_SR_TIME64 + `U2_TIME_LO, lo);
      write_setting(`U2_SR_TIME64 + `U2_TIME_CTRL, 32'd1);
      read_word(4'd1, t0);
      check_value("time high after load", t0, hi);
      k = 10 + $urandom % 20;
      read_word(4'd2, t0);
      repeat (k) @(negedge dsp_clk);
      t1 = rb_data;
      check_value("time low delta", 32'(t1 - t0), 32'(k));

      m = 40 + $urandom % 20;
      pps_captures(m, t0, t1);
      check_value("pps capture delta", 32'(t1 - t0), 32'(m));

      // Armed load takes effect at the first PPS of the pair
      hi = $urandom;
      lo = $urandom & 32'h0FFF_FFFF;
      write_setting(`U2_SR_TIME64 + `U2_TIME_HI, hi);
      write_setting(`U2_SR_TIME64 + `U2_TIME_LO, lo);
      write_setting(`U2_SR_TIME64 + `U2_TIME_CTRL, 32'd0);
      m = 40 + $urandom % 20;
      pps_captures(m, t0, t1);
      // Load and capture share one edge, so the next capture is m - 1 past the staged value
      check_value("pps capture after armed load", t1, 32'(lo + m - 1));
      read_word(4'd3, t0);
      check_value("pps capture high", t0, hi);
   endtask

   task automatic test_framing();
      u2_pkg::stream_line_t ln;
      logic [63:0]          stamp;
      logic [63:0]          prev_stamp;
      int                   base;
      sent_q.delete();
      got_q.delete();
      rx_dst_rdy = 1'b0;
      write_setting(`U2_SR_RX_CTRL + `U2_RX_NSAMPS, 32'(N_SAMPS));
      write_setting(`U2_SR_RX_CTRL + `U2_RX_CMD, 32'(N_PKTS));
      check_value("run_rx on leds_o[1]", leds[1], 1'b1);
      fork
         drive_samples(N_SAMPS * N_PKTS, STB_GAP);
         collect_lines(N_PKTS * (N_SAMPS + 2), 400);
      join
      prev_stamp = '0;
      for (int p = 0; p < N_PKTS; p++) begin
         base = p * (N_SAMPS + 2);
         ln   = got_q[base];
         check_value("header high sof", ln.sof, 1'b1);
         check_value("header high eof", ln.eof, 1'b0);
         stamp[63:32] = ln.payload;
         ln           = got_q[base + 1];
         check_value("header low flags", {ln.sof, ln.eof}, 2'b00);
         stamp[31:0] = ln.payload;
         if (p > 0)
            check_value("timestamp delta", stamp - prev_stamp, 64'(N_SAMPS * STB_GAP));
         prev_stamp = stamp;
         for (int s = 0; s < N_SAMPS; s++) begin
            ln = got_q[base + 2 + s];
            check_value("sample payload", ln.payload, sent_q[p * N_SAMPS + s]);
            check_value("sample sof", ln.sof, 1'b0);
            check_value("sample eof", ln.eof, s == N_SAMPS - 1);
         end
      end
      repeat (4) @(negedge dsp_clk);
      check_value("rx_src_rdy_o after last packet", rx_src_rdy, 1'b0);
      check_value("run_rx on leds_o[1]", leds[1], 1'b0);
      rx_dst_rdy = 1'b0;
   endtask

   task automatic test_overrun();
      u2_pkg::stream_line_t ln;
      int                   waited;
      int                   drained;
      logic                 in_pkt;
      rx_dst_rdy = 1'b0;
      write_setting(`U2_SR_RX_CTRL + `U2_RX_NSAMPS, 32'(N_SAMPS));
      write_setting(`U2_SR_RX_CTRL + `U2_RX_CMD, 32'd100);
      sample_stb = 1'b1;
      sample     = $urandom;
      waited     = 0;
      while (overrun !== 1'b1) begin
         @(negedge dsp_clk);
         sample = $urandom;
         waited++;
         if (waited > 60)
            abort_run("overrun never flagged while the FIFO was blocked");
      end
      sample_stb = 1'b0;
      check_value("run_rx on leds_o[1]", leds[1], 1'b0);
      @(negedge dsp_clk);
      check_value("overrun_o after pulse", overrun, 1'b0);

      //////////////////////////////
      // Drain what the FIFO kept
      drained = 0;
      in_pkt  = 1'b0;
      while (rx_src_rdy) begin
         rx_dst_rdy = 1'b1;
         ln         = rx_line;
         check_value("drained spare bits", ln.spare, 2'b00);
         check_value("sof inside packet", ln.sof && in_pkt, 1'b0);
         check_value("line outside packet", !ln.sof && !in_pkt, 1'b0);
         in_pkt = !ln.eof;
         drained++;
         @(negedge dsp_clk);
      end
      rx_dst_rdy = 1'b0;
      check_value("packet left open", in_pkt, 1'b0);
      check_value("drained within FIFO depth", drained <= `U2_FIFO_DEPTH, 1'b1);
      check_value("drained any line", drained > 0, 1'b1);
   endtask

   //////////////////////////////
   // Sequence
   initial begin
      void'($urandom(32'h944a));
      reset      = 1'b1;
      set_bus    = '0;
      pps        = 1'b0;
      clk_status = 1'b1;
      sample     = '0;
      sample_stb = 1'b0;
      rx_dst_rdy = 1'b0;
      rb_addr    = '0;
      repeat (10) @(negedge dsp_clk);
      reset = 1'b0;

      test_reset_state();
      test_control_regs();
      test_vita_time();
      test_framing();
      test_overrun();

      @(negedge dsp_clk);
      if (UUT.rx_framer.framer_checker.fail_count != 0) begin
         abort_run("stream assertions reported errors");
      end else begin
         $display("Test completed successfully");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
design/u2_pkg.sv
design/u2_setting_regs.sv
design/u2_vita_time.sv
design/u2_rx_framer.sv
design/u2_readback_mux.sv
design/u2_core.sv
verif/u2_core_checker.sv
verif/u2_core_tb.sv

// ==== Bender.yml ====
package:
  name: u2_core

export_include_dirs:
  - include

sources:
  - design/u2_pkg.sv
  - design/u2_setting_regs.sv
  - design/u2_vita_time.sv
  - design/u2_rx_framer.sv
  - design/u2_readback_mux.sv
  - design/u2_core.sv
  - target: simulation
    files:
      - verif/u2_core_checker.sv
      - verif/u2_core_tb.sv
